// File: Bender.yml
package:
  name: sd_dma

sources:
  - sd_dma_pkg.sv
  - adma_fsm.sv
  - burst_engine.sv
  - dma_status.sv
  - sd_dma_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_axi_memory.sv
      - tb_sd_dma.sv

// File: adma_fsm.sv
`timescale 1ns/1ps

module adma_fsm import sd_dma_pkg::*; (
  input  logic                clock,
  input  logic                reset,
  input  logic                start,
  input  logic                dir,
  input  logic [ADDR_W-1:0]   desc_base,
  output logic                cmd_valid,
  output xfer_op_e            cmd_op,
  output logic [ADDR_W-1:0]   cmd_addr,
  output logic [WORDS_W-1:0]  cmd_words,
  input  logic                cmd_ready,
  input  logic                done,
  input  logic [DESC_W-1:0]   desc_word,
  input  logic                bus_err,
  output logic                xfer_end,
  output logic                desc_err
);

  adma_state_e        state;
  logic [ADDR_W-1:0]  desc_ptr;
  logic [DESC_W-1:0]  desc;
  logic               dir_q;

  desc_act_e          desc_act;
  logic               desc_end;
  logic [15:0]        desc_len;
  logic [ADDR_W-1:0]  desc_addr;
  logic [WORDS_W-1:0] tran_words;
  logic [ADDR_W-1:0]  next_ptr;

  //////////////////////////////////////////////////////////////////////
  // Current descriptor fields
  //////////////////////////////////////////////////////////////////////

  assign desc_act  = desc_act_e'(desc[DESC_ACT_LO +: 2]);
  assign desc_end  = desc[DESC_END];
  assign desc_len  = desc[DESC_LEN_LO +: 16];
  assign desc_addr = desc[DESC_ADDR_LO +: ADDR_W];

  // Zero length stands for 65536 bytes
  assign tran_words = (desc_len == 16'd0) ? WORDS_W'(16384)
                                          : {1'b0, desc_len[15:2]};

  // Link jumps, everything else steps to the next line
  assign next_ptr = (desc_act == ACT_LINK) ? desc_addr : desc_ptr + DESC_STRIDE;

  //////////////////////////////////////////////////////////////////////
  // Descriptor state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state     <= ST_STOP;
      cmd_valid <= 1'b0;
      xfer_end  <= 1'b0;
      desc_err  <= 1'b0;
    end else begin
      xfer_end <= 1'b0;
      desc_err <= 1'b0;

      // Command is taken once the engine is idle
      if (cmd_valid && cmd_ready) begin
        cmd_valid <= 1'b0;
      end

      case (state)
        ST_STOP: begin
          if (start) begin
            desc_ptr  <= desc_base;
            dir_q     <= dir;
            cmd_valid <= 1'b1;
            cmd_op    <= OP_FETCH;
            cmd_addr  <= desc_base;
            state     <= ST_FDS;
          end
        end

        ST_FDS: begin
          if (done) begin
            desc <= desc_word;
            if (desc_word[DESC_VALID]) begin
              state <= ST_CADR;
            end else begin
              desc_err <= 1'b1;
              state    <= ST_STOP;
            end
          end
        end

        ST_CADR: begin
          desc_ptr <= next_ptr;
          if (desc_act == ACT_TRAN) begin
            cmd_valid <= 1'b1;
            cmd_op    <= dir_q ? OP_MEM2CARD : OP_CARD2MEM;
            cmd_addr  <= desc_addr;
            cmd_words <= tran_words;
            state     <= ST_TFR;
          end else if (desc_end) begin
            xfer_end <= 1'b1;
            state    <= ST_STOP;
          end else begin
            cmd_valid <= 1'b1;
            cmd_op    <= OP_FETCH;
            cmd_addr  <= next_ptr;
            state     <= ST_FDS;
          end
        end

        ST_TFR: begin
          if (done) begin
            if (desc_end) begin
              xfer_end <= 1'b1;
              state    <= ST_STOP;
            end else begin
              // Pointer already advanced in ST_CADR
              cmd_valid <= 1'b1;
              cmd_op    <= OP_FETCH;
              cmd_addr  <= desc_ptr;
              state     <= ST_FDS;
            end
          end
        end

        default: state <= ST_STOP;
      endcase

      // Error response kills the whole chain
      if (bus_err) begin
        cmd_valid <= 1'b0;
        state     <= ST_STOP;
      end
    end
  end

endmodule

// File: burst_engine.sv
`timescale 1ns/1ps

module burst_engine import sd_dma_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  xfer_op_e              cmd_op,
  input  logic [ADDR_W-1:0]     cmd_addr,
  input  logic [WORDS_W-1:0]    cmd_words,
  output logic                  cmd_ready,
  output logic                  done,
  output logic [DESC_W-1:0]     desc_word,
  output logic                  bus_err,
  output logic [ADDR_W-1:0]     araddr,
  output logic [AXI_LEN_W-1:0]  arlen,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [DATA_W-1:0]     rdata,
  input  logic [AXI_RESP_W-1:0] rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  rready,
  output logic [ADDR_W-1:0]     awaddr,
  output logic [AXI_LEN_W-1:0]  awlen,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [DATA_W-1:0]     wdata,
  output logic                  wlast,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic [AXI_RESP_W-1:0] bresp,
  input  logic                  bvalid,
  output logic                  bready,
  output logic                  card_wr,
  output logic [DATA_W-1:0]     card_data,
  output logic                  card_rd,
  input  logic [DATA_W-1:0]     card_rdata,
  input  logic                  card_fill,
  output logic                  start_write,
  input  logic                  block_done
);

  engine_state_e                    state;
  xfer_op_e                         op;
  logic [ADDR_W-1:0]                addr;
  logic [WORDS_W-1:0]               words_left;
  logic [$clog2(BURST_WORDS)-1:0]   beat_cnt;
  logic [$clog2(BLOCK_WORDS)-1:0]   block_cnt;
  logic [WORDS_W-1:0]               fill_cnt;
  logic [DATA_W-1:0]                desc_lo;
  logic                             err_q;
  logic                             is_read;
  logic                             r_beat;
  logic                             w_beat;

  //////////////////////////////////////////////////////////////////////
  // Channel outputs
  //////////////////////////////////////////////////////////////////////

  assign is_read   = (op != OP_CARD2MEM);
  assign cmd_ready = (state == E_IDLE);

  assign araddr  = addr;
  assign arlen   = (op == OP_FETCH) ? AXI_LEN_W'(FETCH_WORDS - 1)
                                    : AXI_LEN_W'(BURST_WORDS - 1);
  assign arvalid = (state == E_ADDR) && is_read;
  assign rready  = (state == E_DATA) && is_read;
  assign r_beat  = rvalid && rready;

  assign awaddr  = addr;
  assign awlen   = AXI_LEN_W'(BURST_WORDS - 1);
  assign awvalid = (state == E_ADDR) && !is_read;
  assign wvalid  = (state == E_DATA) && !is_read;
  assign wlast   = wvalid && (beat_cnt == BURST_WORDS - 1);
  assign wdata   = card_rdata;
  assign w_beat  = wvalid && wready;

  // Card FIFO moves in lockstep with the bus beats
  assign card_wr   = r_beat && (op == OP_MEM2CARD);
  assign card_data = rdata;
  assign card_rd   = w_beat;

  // Words the serializer has filled but not yet sent to memory
  always_ff @(posedge clock) begin
    if (!reset) begin
      fill_cnt <= '0;
    end else begin
      case ({card_fill, card_rd})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Burst sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state       <= E_IDLE;
      block_cnt   <= '0;
      done        <= 1'b0;
      bus_err     <= 1'b0;
      start_write <= 1'b0;
      bready      <= 1'b0;
    end else begin
      done        <= 1'b0;
      bus_err     <= 1'b0;
      start_write <= 1'b0;
      bready      <= 1'b0;

      case (state)
        E_IDLE: begin
          if (cmd_valid) begin
            op         <= cmd_op;
            addr       <= cmd_addr;
            words_left <= cmd_words;
            state      <= (cmd_op == OP_CARD2MEM) ? E_FILL_WAIT : E_ADDR;
          end
        end

        E_FILL_WAIT: begin
          if (fill_cnt >= BURST_WORDS) begin
            state <= E_ADDR;
          end
        end

        E_ADDR: begin
          if ((arvalid && arready) || (awvalid && awready)) begin
            beat_cnt <= '0;
            err_q    <= 1'b0;
            state    <= E_DATA;
          end
        end

        E_DATA: begin
          if (r_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            err_q    <= err_q | rresp[1];
            if (op == OP_MEM2CARD) begin
              block_cnt <= block_cnt + 1'b1;
            end
            if (beat_cnt == 0) begin
              desc_lo <= rdata;
            end
            if (rlast) begin
              // Drain the whole burst before giving up
              if (err_q || rresp[1]) begin
                bus_err   <= 1'b1;
                block_cnt <= '0;
                state     <= E_IDLE;
              end else if (op == OP_FETCH) begin
                desc_word <= {rdata, desc_lo};
                done      <= 1'b1;
                state     <= E_IDLE;
              end else begin
                addr       <= addr + BURST_BYTES;
                words_left <= words_left - WORDS_W'(BURST_WORDS);
                if (block_cnt == BLOCK_WORDS - 1) begin
                  start_write <= 1'b1;
                end
                if (words_left == WORDS_W'(BURST_WORDS)) begin
                  done  <= 1'b1;
                  state <= E_IDLE;
                end else if (block_cnt == BLOCK_WORDS - 1) begin
                  state <= E_BLOCK_WAIT;
                end else begin
                  state <= E_ADDR;
                end
              end
            end
          end
          if (w_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (wlast) begin
              words_left <= words_left - WORDS_W'(BURST_WORDS);
              state      <= E_RESP;
            end
          end
        end

        E_BLOCK_WAIT: begin
          if (block_done) begin
            state <= E_ADDR;
          end
        end

        E_RESP: begin
          // bready is a one-cycle answer to bvalid
          bready <= bvalid && !bready;
          if (bvalid && bready) begin
            if (bresp[1]) begin
              bus_err <= 1'b1;
              state   <= E_IDLE;
            end else begin
              addr <= addr + BURST_BYTES;
              if (words_left == '0) begin
                done  <= 1'b1;
                state <= E_IDLE;
              end else begin
                state <= E_FILL_WAIT;
              end
            end
          end
        end

        default: state <= E_IDLE;
      endcase
    end
  end

endmodule

// File: dma_status.sv
`timescale 1ns/1ps

module dma_status import sd_dma_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic             xfer_end,
  input  logic             desc_err,
  input  logic             bus_err,
  input  logic             int_clear,
  output logic [IRQ_W-1:0] irq
);

  logic [IRQ_W-1:0] irq_set;

  //////////////////////////////////////////////////////////////////////
  // Event pulses mapped onto the vector
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    irq_set               = '0;
    irq_set[IRQ_XFER]     = xfer_end;
    irq_set[IRQ_DESC_ERR] = desc_err;
    irq_set[IRQ_BUS_ERR]  = bus_err;
  end

  // Sticky bits, a new event beats a clear in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      irq <= '0;
    end else if (int_clear) begin
      irq <= irq_set;
    end else begin
      irq <= irq | irq_set;
    end
  end

endmodule

// File: sd_dma.f
sd_dma_pkg.sv
adma_fsm.sv
burst_engine.sv
dma_status.sv
sd_dma_top.sv
tb_clock_gen.sv
tb_axi_memory.sv
tb_sd_dma.sv

// File: sd_dma_pkg.sv
package sd_dma_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and descriptor geometry
  //////////////////////////////////////////////////////////////////////

  localparam int DESC_W     = 64;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_LEN_W  = 8;
  localparam int AXI_RESP_W = 2;
  localparam int IRQ_W      = 3;

  // 16 words per burst, addresses step by 64 bytes
  localparam int BURST_WORDS = 16;
  localparam logic [ADDR_W-1:0] BURST_BYTES = BURST_WORDS * 4;

  // Card block size in words, engine pauses after each one
  localparam int BLOCK_WORDS = 128;

  // Enough for a 64 KiB descriptor (16384 words)
  localparam int WORDS_W = 15;

  // Descriptor fetch is one two-beat read
  localparam int FETCH_WORDS = 2;
  localparam logic [ADDR_W-1:0] DESC_STRIDE = 8;

  // Descriptor field positions
  localparam int DESC_VALID   = 0;
  localparam int DESC_END     = 1;
  localparam int DESC_ACT_LO  = 4;
  localparam int DESC_LEN_LO  = 16;
  localparam int DESC_ADDR_LO = 32;

  //////////////////////////////////////////////////////////////////////
  // States and opcodes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {ST_STOP, ST_FDS, ST_CADR, ST_TFR} adma_state_e;

  // Encoding taken from the ADMA2 action field
  typedef enum logic [1:0] {ACT_NOP, ACT_RSV, ACT_TRAN, ACT_LINK} desc_act_e;

  typedef enum logic [1:0] {OP_FETCH, OP_MEM2CARD, OP_CARD2MEM} xfer_op_e;

  typedef enum logic [2:0] {
    E_IDLE, E_ADDR, E_DATA, E_BLOCK_WAIT, E_FILL_WAIT, E_RESP
  } engine_state_e;

  // Bit positions in the interrupt vector
  typedef enum logic [1:0] {IRQ_XFER = 0, IRQ_DESC_ERR = 1, IRQ_BUS_ERR = 2} irq_e;

endpackage

// File: sd_dma_top.sv
`timescale 1ns/1ps

module sd_dma_top import sd_dma_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  dir,
  input  logic [ADDR_W-1:0]     desc_base,
  input  logic                  int_clear,
  output logic [IRQ_W-1:0]      irq,
  // AXI master
  output logic [ADDR_W-1:0]     araddr,
  output logic [AXI_LEN_W-1:0]  arlen,
  output logic                  arvalid,
  input  logic                  arready,
  input  logic [DATA_W-1:0]     rdata,
  input  logic [AXI_RESP_W-1:0] rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  rready,
  output logic [ADDR_W-1:0]     awaddr,
  output logic [AXI_LEN_W-1:0]  awlen,
  output logic                  awvalid,
  input  logic                  awready,
  output logic [DATA_W-1:0]     wdata,
  output logic                  wlast,
  output logic                  wvalid,
  input  logic                  wready,
  input  logic [AXI_RESP_W-1:0] bresp,
  input  logic                  bvalid,
  output logic                  bready,
  // Card FIFO
  output logic                  card_wr,
  output logic [DATA_W-1:0]     card_data,
  output logic                  card_rd,
  input  logic [DATA_W-1:0]     card_rdata,
  input  logic                  card_fill,
  output logic                  start_write,
  input  logic                  block_done
);

  logic               cmd_valid;
  xfer_op_e           cmd_op;
  logic [ADDR_W-1:0]  cmd_addr;
  logic [WORDS_W-1:0] cmd_words;
  logic               cmd_ready;
  logic               done;
  logic [DESC_W-1:0]  desc_word;
  logic               bus_err;
  logic               xfer_end;
  logic               desc_err;

  adma_fsm u_fsm (
    .clock, .reset,
    .start, .dir, .desc_base,
    .cmd_valid, .cmd_op, .cmd_addr, .cmd_words, .cmd_ready,
    .done, .desc_word, .bus_err,
    .xfer_end, .desc_err
  );

  burst_engine u_engine (
    .clock, .reset,
    .cmd_valid, .cmd_op, .cmd_addr, .cmd_words, .cmd_ready,
    .done, .desc_word, .bus_err,
    .araddr, .arlen, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .awaddr, .awlen, .awvalid, .awready,
    .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .card_wr, .card_data, .card_rd, .card_rdata,
    .card_fill, .start_write, .block_done
  );

  dma_status u_status (
    .clock, .reset,
    .xfer_end, .desc_err, .bus_err,
    .int_clear,
    .irq
  );

endmodule

// File: sd_dma_trace.txt
# test: name dir(1 = mem to card) table err_addr xfer desc_err bus_err
#       check_addr check_words start_writes card_base   (addresses in hex)
# desc: address high_word low_word, one descriptor stored low word first
test mem2card_end 1 00000100 ffffffff 1 0 0 00001000 256 2 00000000
desc 00000100 00001000 04000023
test card2mem_end 0 00000200 ffffffff 1 0 0 00002000 64 0 00c00000
desc 00000200 00002000 01000023
test bus_error 1 00000600 00003050 0 0 1 00003000 32 0 00000000
desc 00000600 00003000 04000023
test link_nop_tran 1 00000300 ffffffff 1 0 0 00004000 128 1 00000000
desc 00000300 00000400 00000031
desc 00000308 00005000 02000023
desc 00000400 00000000 00000001
desc 00000408 00004000 02000023
test desc_invalid 1 00000500 ffffffff 0 1 0 00001000 0 0 00000000
desc 00000500 00001000 04000022

// File: tb_axi_memory.sv
`timescale 1ns/1ps

module tb_axi_memory import sd_dma_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [ADDR_W-1:0]     err_addr,
  input  logic [ADDR_W-1:0]     araddr,
  input  logic [AXI_LEN_W-1:0]  arlen,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [DATA_W-1:0]     rdata,
  output logic [AXI_RESP_W-1:0] rresp,
  output logic                  rlast,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic [ADDR_W-1:0]     awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [DATA_W-1:0]     wdata,
  input  logic                  wlast,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [AXI_RESP_W-1:0] bresp,
  output logic                  bvalid,
  input  logic                  bready
);

  localparam int MEM_WORDS = 16384;

  // 64 KiB, word index is address bits 15..2
  logic [DATA_W-1:0] mem [MEM_WORDS];

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] wr_addr;
    int                rd_left;
    logic              rd_busy;
    logic              wr_busy;
    logic              wr_err;
    logic              b_pend;
    rnd     = 32'h9bc1_423e;
    rd_addr = '0;
    wr_addr = '0;
    rd_left = 0;
    rd_busy = 1'b0;
    wr_busy = 1'b0;
    wr_err  = 1'b0;
    b_pend  = 1'b0;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = '0;
    rlast   = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bresp   = '0;
    forever begin
      @(posedge clock);
      // Handshakes seen on this edge
      if (!reset) begin
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        b_pend  = 1'b0;
      end else begin
        if (arvalid && arready) begin
          rd_addr = araddr;
          rd_left = int'(arlen) + 1;
          rd_busy = 1'b1;
        end else if (rvalid && rready) begin
          rd_addr = rd_addr + 4;
          rd_left = rd_left - 1;
          rd_busy = (rd_left != 0);
        end
        if (awvalid && awready) begin
          wr_addr = awaddr;
          wr_busy = 1'b1;
          wr_err  = 1'b0;
        end
        if (wvalid && wready) begin
          if (wr_addr == err_addr) begin
            wr_err = 1'b1;
          end else begin
            mem[wr_addr[15:2]] = wdata;
          end
          wr_addr = wr_addr + 4;
          if (wlast) begin
            wr_busy = 1'b0;
            b_pend  = 1'b1;
          end
        end
        if (bvalid && bready) begin
          b_pend = 1'b0;
        end
      end
      #1;
      // Random stalls on the ready signals
      rnd     = xorshift32(rnd);
      arready = !rd_busy && (rnd[1:0] != 2'b00);
      awready = !wr_busy && !b_pend && (rnd[5:4] != 2'b00);
      wready  = wr_busy && (rnd[3:2] != 2'b00);
      rvalid  = rd_busy;
      rdata   = mem[rd_addr[15:2]];
      rresp   = (rd_busy && rd_addr == err_addr) ? 2'b10 : 2'b00;
      rlast   = rd_busy && (rd_left == 1);
      bvalid  = b_pend;
      bresp   = wr_err ? 2'b10 : 2'b00;
    end
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Held low for three rising edges
  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

// File: tb_sd_dma.sv
`timescale 1ns/1ps

module tb_sd_dma import sd_dma_pkg::*; ();

  localparam int MAX_TESTS = 8;
  localparam int MAX_DESCS = 32;
  localparam int MEM_WORDS = 16384;
  localparam int DONE_WAIT = 8;

  logic                  clock;
  logic                  reset;
  logic                  start;
  logic                  dir;
  logic [ADDR_W-1:0]     desc_base;
  logic                  int_clear;
  logic [IRQ_W-1:0]      irq;
  logic [ADDR_W-1:0]     araddr;
  logic [AXI_LEN_W-1:0]  arlen;
  logic                  arvalid;
  logic                  arready;
  logic [DATA_W-1:0]     rdata;
  logic [AXI_RESP_W-1:0] rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;
  logic [ADDR_W-1:0]     awaddr;
  logic [AXI_LEN_W-1:0]  awlen;
  logic                  awvalid;
  logic                  awready;
  logic [DATA_W-1:0]     wdata;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic [AXI_RESP_W-1:0] bresp;
  logic                  bvalid;
  logic                  bready;
  logic                  card_wr;
  logic [DATA_W-1:0]     card_data;
  logic                  card_rd;
  logic [DATA_W-1:0]     card_rdata;
  logic                  card_fill;
  logic                  start_write;
  logic                  block_done;
  logic [ADDR_W-1:0]     err_addr;

  // Tests and descriptors from the trace
  string             t_name [MAX_TESTS];
  int                t_dir [MAX_TESTS];
  logic [ADDR_W-1:0] t_table [MAX_TESTS];
  logic [ADDR_W-1:0] t_err [MAX_TESTS];
  logic [IRQ_W-1:0]  t_irq [MAX_TESTS];
  logic [ADDR_W-1:0] t_chk_addr [MAX_TESTS];
  int                t_chk_words [MAX_TESTS];
  int                t_blocks [MAX_TESTS];
  logic [ADDR_W-1:0] t_card_base [MAX_TESTS];
  int                d_test [MAX_DESCS];
  logic [ADDR_W-1:0] d_addr [MAX_DESCS];
  logic [DATA_W-1:0] d_hi [MAX_DESCS];
  logic [DATA_W-1:0] d_lo [MAX_DESCS];
  int                num_tests;
  int                num_descs;

  // Running state shared with the monitors
  string             cur_name;
  int                cur_dir;
  int                cur_words;
  logic [ADDR_W-1:0] cur_chk_addr;
  int                card_seen;
  int                w_seen;
  int                sw_seen;
  int                fill_left;
  int                fill_idx;
  logic [ADDR_W-1:0] fill_base;
  logic [DATA_W-1:0] card_q [$];
  int                checks;
  int                errors;
  int                cycle_count;
  int                cycle_limit;

  tb_clock_gen clk_gen (.clock, .reset);

  tb_axi_memory axi_mem (
    .clock, .reset, .err_addr,
    .araddr, .arlen, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .awaddr, .awvalid, .awready,
    .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready
  );

  sd_dma_top dut (
    .clock, .reset, .start, .dir, .desc_base, .int_clear, .irq,
    .araddr, .arlen, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .awaddr, .awlen, .awvalid, .awready,
    .wdata, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .card_wr, .card_data, .card_rd, .card_rdata,
    .card_fill, .start_write, .block_done
  );

  // Memory and card data pattern, mixes every address bit
  function automatic logic [DATA_W-1:0] image_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a3c_0f96;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_word(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_irq(input string what, input logic [IRQ_W-1:0] got,
                             input logic [IRQ_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s irq got xfer %b desc_err %b bus_err %b, expected %b",
               $time, what, got[IRQ_XFER], got[IRQ_DESC_ERR], got[IRQ_BUS_ERR], exp);
    end
  endtask

  task automatic compare_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace and memory image
  //////////////////////////////////////////////////////////////////////

  task automatic read_trace();
    int                fd;
    int                n;
    int                xf;
    int                de;
    int                be;
    string             line;
    string             kw;
    string             name;
    logic [IRQ_W-1:0]  exp_irq;
    fd = $fopen("sd_dma_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open trace file sd_dma_trace.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        kw = "";
        n  = $sscanf(line, "%s", kw);
        if (kw == "test" && num_tests < MAX_TESTS) begin
          n = $sscanf(line, "%s %s %d %h %h %d %d %d %h %d %d %h", kw, name,
                      t_dir[num_tests], t_table[num_tests], t_err[num_tests], xf, de, be,
                      t_chk_addr[num_tests], t_chk_words[num_tests], t_blocks[num_tests],
                      t_card_base[num_tests]);
          if (n != 12) begin
            $display("trace test line has %0d fields instead of 12", n);
            errors++;
          end
          exp_irq               = '0;
          exp_irq[IRQ_XFER]     = (xf != 0);
          exp_irq[IRQ_DESC_ERR] = (de != 0);
          exp_irq[IRQ_BUS_ERR]  = (be != 0);
          t_irq[num_tests]      = exp_irq;
          t_name[num_tests]     = name;
          num_tests++;
        end else if (kw == "desc" && num_descs < MAX_DESCS) begin
          n = $sscanf(line, "%s %h %h %h", kw, d_addr[num_descs], d_hi[num_descs],
                      d_lo[num_descs]);
          if (n != 4) begin
            $display("trace desc line has %0d fields instead of 4", n);
            errors++;
          end
          d_test[num_descs] = num_tests - 1;
          num_descs++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Fresh pattern, then the test's descriptors, low word first
  task automatic load_image(input int t);
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      axi_mem.mem[i] = image_word(32'(i * 4));
    end
    for (i = 0; i < num_descs; i++) begin
      if (d_test[i] == t) begin
        axi_mem.mem[d_addr[i][15:2]]     = d_lo[i];
        axi_mem.mem[d_addr[i][15:2] + 1] = d_hi[i];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One test, entered and left 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    int errors_before;
    int k;
    int idx;
    errors_before = errors;
    load_image(t);
    cur_name     = t_name[t];
    cur_dir      = t_dir[t];
    cur_words    = t_chk_words[t];
    cur_chk_addr = t_chk_addr[t];
    card_seen    = 0;
    w_seen       = 0;
    sw_seen      = 0;
    err_addr     = t_err[t];
    fill_base    = t_card_base[t];
    fill_idx     = 0;
    fill_left    = (t_dir[t] == 0) ? t_chk_words[t] : 0;
    start        = 1'b1;
    dir          = (t_dir[t] != 0);
    desc_base    = t_table[t];
    @(posedge clock);
    #1;
    start = 1'b0;

    // Every ending sets some interrupt bit
    while (irq == '0) begin
      @(posedge clock);
    end
    repeat (DONE_WAIT) @(posedge clock);
    compare_irq("end of run", irq, t_irq[t]);
    compare_count("card words", card_seen, (t_dir[t] != 0) ? t_chk_words[t] : 0);
    compare_count("start_write pulses", sw_seen, t_blocks[t]);
    compare_count("memory write beats", w_seen, (t_dir[t] == 0) ? t_chk_words[t] : 0);
    if (t_dir[t] == 0) begin
      for (k = 0; k < t_chk_words[t]; k++) begin
        idx = int'(t_chk_addr[t][15:2]) + k;
        compare_word($sformatf("memory word %0d", k), axi_mem.mem[idx],
                     image_word(t_card_base[t] + 32'(4 * k)));
      end
    end

    #1;
    int_clear = 1'b1;
    @(posedge clock);
    #1;
    int_clear = 1'b0;
    @(posedge clock);
    compare_irq("after int_clear", irq, '0);
    if (errors == errors_before) begin
      $display("test %s: ok", t_name[t]);
    end else begin
      $display("test %s: %0d errors", t_name[t], errors - errors_before);
    end
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Card FIFO model and monitors
  //////////////////////////////////////////////////////////////////////

  initial begin
    int bd_wait;
    int pace;
    bd_wait    = 0;
    pace       = 0;
    card_fill  = 1'b0;
    card_rdata = '0;
    block_done = 1'b0;
    forever begin
      @(posedge clock);
      if (card_rd) begin
        if (card_q.size() == 0) begin
          $display("card FIFO read while empty at %0t", $time);
          errors++;
        end else begin
          void'(card_q.pop_front());
        end
      end
      if (start_write) begin
        bd_wait = 4;
      end
      #1;
      card_fill  = 1'b0;
      block_done = 1'b0;
      if (bd_wait > 0) begin
        bd_wait--;
        block_done = (bd_wait == 0);
      end
      // Serializer delivers a word every third cycle
      pace++;
      if (fill_left > 0 && pace % 3 == 0) begin
        card_q.push_back(image_word(fill_base + 32'(4 * fill_idx)));
        fill_idx++;
        fill_left--;
        card_fill = 1'b1;
      end
      card_rdata = (card_q.size() != 0) ? card_q[0] : '0;
    end
  end

  always @(posedge clock) begin
    if (card_wr) begin
      compare_word($sformatf("card word %0d", card_seen), card_data,
                   image_word(cur_chk_addr + 32'(4 * card_seen)));
      card_seen++;
    end
    if (awvalid && awready) begin
      compare_count("awlen", int'(awlen), BURST_WORDS - 1);
    end
    if (wvalid && wready) begin
      w_seen++;
    end
    if (start_write) begin
      sw_seen++;
    end
  end

  initial begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout after %0d cycles in test %s, %0d of %0d words never completed",
             cycle_count, cur_name, cur_words - ((cur_dir != 0) ? card_seen : w_seen),
             cur_words);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int t;
    int total;
    start       = 1'b0;
    dir         = 1'b0;
    desc_base   = '0;
    int_clear   = 1'b0;
    err_addr    = '1;
    checks      = 0;
    errors      = 0;
    num_tests   = 0;
    num_descs   = 0;
    cycle_count = 0;
    cycle_limit = 0;
    cur_name    = "none";
    read_trace();
    total = 0;
    for (t = 0; t < num_tests; t++) begin
      total += t_chk_words[t];
    end
    cycle_limit = 40 * total + 2000;
    while (reset !== 1'b1) begin
      @(posedge clock);
    end
    @(posedge clock);
    #1;
    for (t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
